//--- firPkg.sv
`default_nettype none

package firPkg;

    // Filter geometry
    localparam int TAPS         = 16;
    localparam int HALF_TAPS    = 8;
    localparam int DECIMATION   = 4;
    localparam int FILL_STROBES = TAPS / DECIMATION;

    // Datapath widths
    localparam int COEFF_W = 10;
    localparam int HALF_W  = 13;
    localparam int ACC_W   = 14;
    localparam int OUT_W   = 12;

    // Wishbone widths
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 16;

    typedef logic signed [COEFF_W-1:0]       coeff_t;
    typedef logic [HALF_TAPS*COEFF_W-1:0]    coeffBank_t;
    typedef logic [HALF_TAPS-1:0]            taps_t;
    typedef logic signed [HALF_W-1:0]        halfSum_t;
    typedef logic signed [ACC_W-1:0]         acc_t;
    typedef logic [OUT_W-1:0]                sample_t;
    typedef logic [WB_ADR_W-1:0]             wbAdr_t;
    typedef logic [WB_DAT_W-1:0]             wbDat_t;

    // Master to slave
    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        wbAdr_t adr;
        wbDat_t dat;
    } wbReq_t;

    // Slave to master
    typedef struct packed {
        logic   ack;
        wbDat_t dat;
    } wbRsp_t;

endpackage

`default_nettype wire

//--- coeffRegs.sv
`default_nettype none

module coeffRegs (
    input  logic               clk,
    input  logic               arstN,
    input  firPkg::wbReq_t     wbReq,
    output firPkg::wbRsp_t     wbRsp,
    output firPkg::coeffBank_t lookaheadCoeffs,
    output firPkg::coeffBank_t lookbackCoeffs
);
    import firPkg::*;

    localparam int NUM_COEFFS = 2 * HALF_TAPS;

    coeff_t coeffMem [NUM_COEFFS];
    logic   ackQ;
    wbDat_t rdDatQ;
    logic   reqHit;

    // New request only, so ack never repeats for one cycle
    assign reqHit = wbReq.cyc && wbReq.stb && !ackQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= reqHit;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_COEFFS; i++) begin
                coeffMem[i] <= '0;
            end
        end else if (reqHit && wbReq.we) begin
            coeffMem[wbReq.adr] <= coeff_t'(wbReq.dat[COEFF_W-1:0]);
        end
    end

    // Read data, sign-extended to the bus width
    always_ff @(posedge clk) begin
        if (reqHit) begin
            rdDatQ <= {{(WB_DAT_W - COEFF_W){coeffMem[wbReq.adr][COEFF_W-1]}},
                       coeffMem[wbReq.adr]};
        end
    end

    assign wbRsp = '{ack: ackQ, dat: rdDatQ};

    // Registers 0..7 feed the lookahead half, 8..15 the lookback half
    always_comb begin
        for (int i = 0; i < HALF_TAPS; i++) begin
            lookaheadCoeffs[i*COEFF_W +: COEFF_W] = coeffMem[i];
            lookbackCoeffs[i*COEFF_W +: COEFF_W]  = coeffMem[HALF_TAPS + i];
        end
    end

endmodule

`default_nettype wire

//--- tapHistory.sv
`default_nettype none

module tapHistory (
    input  logic          clk,
    input  logic          arstN,
    input  logic          bitIn,
    output firPkg::taps_t lookaheadTaps,
    output firPkg::taps_t lookbackTaps,
    output logic          tapsValid
);
    import firPkg::*;

    localparam int PHASE_W    = $clog2(DECIMATION);
    localparam int FILL_CNT_W = $clog2(FILL_STROBES + 1);

    logic [PHASE_W-1:0]    phase;
    logic                  strobe;
    logic [DECIMATION-2:0] collectBits;
    logic [TAPS-1:0]       history;
    logic [FILL_CNT_W-1:0] fillCnt;

    // Last phase of the window, the current bit completes the group
    assign strobe = (phase == PHASE_W'(DECIMATION - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase     <= '0;
            fillCnt   <= '0;
            tapsValid <= 1'b0;
        end else begin
            phase     <= phase + 1'b1;
            tapsValid <= strobe && (fillCnt >= FILL_CNT_W'(FILL_STROBES - 1));
            if (strobe && (fillCnt != FILL_CNT_W'(FILL_STROBES))) begin
                fillCnt <= fillCnt + 1'b1;
            end
        end
    end

    // Bit 0 of history is the newest, age 0
    always_ff @(posedge clk) begin
        collectBits <= {collectBits[DECIMATION-3:0], bitIn};
        if (strobe) begin
            history <= {history[TAPS-DECIMATION-1:0], collectBits, bitIn};
        end
    end

    // Lookahead reversed, lookback in age order
    always_comb begin
        for (int i = 0; i < HALF_TAPS; i++) begin
            lookaheadTaps[i] = history[HALF_TAPS - 1 - i];
            lookbackTaps[i]  = history[HALF_TAPS + i];
        end
    end

endmodule

`default_nettype wire

//--- tapGroupSum.sv
`default_nettype none

module tapGroupSum (
    input  logic               clk,
    input  logic               arstN,
    input  firPkg::taps_t      taps,
    input  firPkg::coeffBank_t coeffs,
    input  logic               inValid,
    output firPkg::halfSum_t   sum,
    output logic               sumValid
);
    import firPkg::*;

    localparam int GROUPS     = 2;
    localparam int GROUP_TAPS = HALF_TAPS / GROUPS;

    halfSum_t groupSum [GROUPS];
    halfSum_t partialQ [GROUPS];
    logic     partialValid;

    // Each tap adds or subtracts its coefficient
    always_comb begin : groupAdd
        coeff_t   c;
        halfSum_t term;
        int       idx;
        for (int g = 0; g < GROUPS; g++) begin
            groupSum[g] = '0;
            for (int j = 0; j < GROUP_TAPS; j++) begin
                idx  = g * GROUP_TAPS + j;
                c    = coeff_t'(coeffs[idx*COEFF_W +: COEFF_W]);
                term = {{(HALF_W - COEFF_W){c[COEFF_W-1]}}, c};
                if (taps[idx]) begin
                    groupSum[g] = groupSum[g] + term;
                end else begin
                    groupSum[g] = groupSum[g] - term;
                end
            end
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        for (int g = 0; g < GROUPS; g++) begin
            partialQ[g] <= groupSum[g];
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        sum <= partialQ[0] + partialQ[1];
    end

    // Valid tag alongside the data
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            partialValid <= 1'b0;
            sumValid     <= 1'b0;
        end else begin
            partialValid <= inValid;
            sumValid     <= partialValid;
        end
    end

endmodule

`default_nettype wire

//--- outputScaler.sv
`default_nettype none

module outputScaler (
    input  logic             clk,
    input  logic             arstN,
    input  firPkg::halfSum_t lookaheadSum,
    input  firPkg::halfSum_t lookbackSum,
    input  logic             inValid,
    output firPkg::sample_t  sampleOut,
    output logic             sampleValid
);
    import firPkg::*;

    acc_t total;
    acc_t totalQ;
    logic totalValid;

    assign total = {{(ACC_W - HALF_W){lookaheadSum[HALF_W-1]}}, lookaheadSum}
                 + {{(ACC_W - HALF_W){lookbackSum[HALF_W-1]}}, lookbackSum};

    always_ff @(posedge clk) begin
        totalQ <= total;
    end

    // Floor shift by dropping the low bits, then flip the sign bit for offset binary
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            totalValid  <= 1'b0;
            sampleValid <= 1'b0;
            sampleOut   <= '0;
        end else begin
            totalValid  <= inValid;
            sampleValid <= totalValid;
            if (totalValid) begin
                sampleOut <= {~totalQ[ACC_W-1], totalQ[ACC_W-2 -: OUT_W-1]};
            end
        end
    end

endmodule

`default_nettype wire

//--- firDecimator.sv
`default_nettype none

module firDecimator (
    input  logic            clk,
    input  logic            arstN,
    input  logic            bitIn,
    input  firPkg::wbReq_t  wbReq,
    output firPkg::wbRsp_t  wbRsp,
    output firPkg::sample_t sampleOut,
    output logic            sampleValid
);
    import firPkg::*;

    coeffBank_t lookaheadCoeffs;
    coeffBank_t lookbackCoeffs;
    taps_t      lookaheadTaps;
    taps_t      lookbackTaps;
    logic       tapsValid;
    halfSum_t   lookaheadResult;
    halfSum_t   lookbackResult;
    logic       halfValid;

    coeffRegs coeffRegs (
        .clk             (clk),
        .arstN           (arstN),
        .wbReq           (wbReq),
        .wbRsp           (wbRsp),
        .lookaheadCoeffs (lookaheadCoeffs),
        .lookbackCoeffs  (lookbackCoeffs)
    );

    tapHistory tapHistory (
        .clk           (clk),
        .arstN         (arstN),
        .bitIn         (bitIn),
        .lookaheadTaps (lookaheadTaps),
        .lookbackTaps  (lookbackTaps),
        .tapsValid     (tapsValid)
    );

    tapGroupSum lookaheadSum (
        .clk      (clk),
        .arstN    (arstN),
        .taps     (lookaheadTaps),
        .coeffs   (lookaheadCoeffs),
        .inValid  (tapsValid),
        .sum      (lookaheadResult),
        .sumValid (halfValid)
    );

    // Same timing as the lookahead unit, its tag is redundant
    tapGroupSum lookbackSum (
        .clk      (clk),
        .arstN    (arstN),
        .taps     (lookbackTaps),
        .coeffs   (lookbackCoeffs),
        .inValid  (tapsValid),
        .sum      (lookbackResult),
        .sumValid ()
    );

    outputScaler outputScaler (
        .clk          (clk),
        .arstN        (arstN),
        .lookaheadSum (lookaheadResult),
        .lookbackSum  (lookbackResult),
        .inValid      (halfValid),
        .sampleOut    (sampleOut),
        .sampleValid  (sampleValid)
    );

endmodule

`default_nettype wire

//--- firDecimator_props.sv
`default_nettype none

module firDecimatorProps (
    input logic            clk,
    input logic            arstN,
    input firPkg::wbReq_t  wbReq,
    input firPkg::wbRsp_t  wbRsp,
    input firPkg::sample_t sampleOut,
    input logic            sampleValid,
    input logic            tapsValid
);
    import firPkg::*;

    // Keeps $past away from the first edge
    logic armed = 1'b0;

    always @(posedge clk) begin
        armed <= 1'b1;
    end

    ackAfterReq: assert property (@(posedge clk) disable iff (!arstN)
        armed && wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb))
        else $error("ack without a request in the previous cycle");

    ackSingle: assert property (@(posedge clk) disable iff (!arstN)
        armed && wbRsp.ack |-> !$past(wbRsp.ack))
        else $error("ack high in two consecutive cycles");

    validSpacing: assert property (@(posedge clk) disable iff (!arstN)
        armed && sampleValid |->
            !$past(sampleValid, 1) && !$past(sampleValid, 2) && !$past(sampleValid, 3))
        else $error("sampleValid pulses closer than the decimation period");

    validPeriod: assert property (@(posedge clk) disable iff (!arstN)
        armed && $past(sampleValid, DECIMATION) |-> sampleValid)
        else $error("sampleValid missed its decimation slot");

    // Four clocks from taps to output
    validLatency: assert property (@(posedge clk) disable iff (!arstN)
        armed && sampleValid |-> $past(tapsValid, 4))
        else $error("sampleValid not four clocks after a full strobe");

    resetValues: assert property (@(posedge clk)
        armed && !arstN |-> !wbRsp.ack && !sampleValid && sampleOut == '0)
        else $error("outputs not cleared during reset");

endmodule

bind firDecimator firDecimatorProps props (
    .clk         (clk),
    .arstN       (arstN),
    .wbReq       (wbReq),
    .wbRsp       (wbRsp),
    .sampleOut   (sampleOut),
    .sampleValid (sampleValid),
    .tapsValid   (tapsValid)
);

`default_nettype wire

//--- firDecimatorTb.sv
`default_nettype none

module firDecimatorTb;
    import firPkg::*;

    localparam int RESET_CYCLES   = 16;
    // About three times the length of all tests together
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int FILL_LATENCY   = DECIMATION * FILL_STROBES + 4;
    localparam int MIN_SAMPLES    = 50;
    localparam int MODE_RANDOM    = 0;
    localparam int MODE_ONES      = 1;
    localparam int MODE_ZEROS     = 2;

    logic    clk;
    logic    arstN;
    logic    bitIn;
    wbReq_t  wbReq;
    wbRsp_t  wbRsp;
    sample_t sampleOut;
    logic    sampleValid;

    int              seed = 13;
    int              bitMode;
    int              cycleCnt;
    int              relEdges;
    int              fillStrobes;
    int              samplesChecked;
    int              modelCoeffs [TAPS];
    logic [TAPS-1:0] recentBits;
    logic [TAPS-1:0] snapHist;
    logic            pendingCompute;
    sample_t         expQ [$];
    int              dueQ [$];

    firDecimator dut (
        .clk         (clk),
        .arstN       (arstN),
        .bitIn       (bitIn),
        .wbReq       (wbReq),
        .wbRsp       (wbRsp),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid)
    );

    always #50 clk = ~clk;

    task automatic failRun();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        failRun();
    endtask

    task automatic reportMismatch(input string name, input int expected, input int actual);
        $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
        failRun();
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    // Age 0 is the newest bit, ages 0..7 use registers 7..0
    function automatic sample_t expectedSample(input logic [TAPS-1:0] hist);
        int total;
        int scaled;
        int c;
        total = 0;
        for (int age = 0; age < TAPS; age++) begin
            c = (age < HALF_TAPS) ? modelCoeffs[HALF_TAPS - 1 - age] : modelCoeffs[age];
            total += hist[age] ? c : -c;
        end
        scaled = total >>> 2;
        return sample_t'(scaled) ^ sample_t'(1 << (OUT_W - 1));
    endfunction

    function automatic coeff_t randomCoeff();
        int r;
        r = $random(seed);
        return coeff_t'(r);
    endfunction

    // One classic cycle, returns in the cycle that carries ack
    task automatic busCycle(input logic we, input wbAdr_t adr, input wbDat_t dat,
                            output wbDat_t rdDat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        assert (!wbRsp.ack) else reportMismatch("wbRsp.ack", 0, int'(wbRsp.ack));
        nextCycle();
        assert (wbRsp.ack) else reportMismatch("wbRsp.ack", 1, int'(wbRsp.ack));
        rdDat = wbRsp.dat;
        wbReq = '0;
    endtask

    // The register changes at the ack edge, so the model follows during ack
    task automatic writeCoeff(input int idx, input coeff_t value);
        wbDat_t unused;
        busCycle(1'b1, wbAdr_t'(idx), wbDat_t'(value), unused);
        modelCoeffs[idx] = int'(value);
        nextCycle();
    endtask

    task automatic readCoeffCheck(input int idx);
        wbDat_t rdDat;
        wbDat_t expected;
        busCycle(1'b0, wbAdr_t'(idx), '0, rdDat);
        nextCycle();
        expected = wbDat_t'(modelCoeffs[idx]);
        assert (rdDat == expected) else reportMismatch("wbRsp.dat", int'(expected), int'(rdDat));
    endtask

    task automatic writeAllCoeffs(input int value);
        for (int i = 0; i < TAPS; i++) begin
            writeCoeff(i, coeff_t'(value));
        end
    endtask

    task automatic waitSamples(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            nextCycle();
            if (sampleValid) begin
                seen++;
            end
        end
    endtask

    // Called right after reset release
    task automatic checkFillDelay();
        int   n;
        logic seenValid;
        n = 0;
        seenValid = 1'b0;
        while (!seenValid) begin
            nextCycle();
            n++;
            seenValid = sampleValid;
        end
        assert (n == FILL_LATENCY) else reportMismatch("sampleValid delay", FILL_LATENCY, n);
    endtask

    task automatic checkHeldSample(input int expected);
        assert (sampleOut == sample_t'(expected))
        else reportMismatch("sampleOut", expected, int'(sampleOut));
    endtask

    // Bit source, drawn at the edge and driven a little later
    always begin
        int r;
        @(posedge clk);
        r = $random(seed);
        #10;
        case (bitMode)
            MODE_ONES:  bitIn = 1'b1;
            MODE_ZEROS: bitIn = 1'b0;
            default:    bitIn = r[0];
        endcase
    end

    // Reference model of the history and strobe timing
    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            abortRun("Timeout: the tests did not finish within the cycle limit");
        end
        if (!arstN) begin
            relEdges       = 0;
            fillStrobes    = 0;
            pendingCompute = 1'b0;
            expQ.delete();
            dueQ.delete();
        end else begin
            recentBits = {recentBits[TAPS-2:0], bitIn};
            // Sum stage samples taps and coefficients one edge after the strobe
            if (pendingCompute) begin
                expQ.push_back(expectedSample(snapHist));
                dueQ.push_back(cycleCnt + 3);
                pendingCompute = 1'b0;
            end
            relEdges++;
            if (relEdges % DECIMATION == 0) begin
                if (fillStrobes < FILL_STROBES) begin
                    fillStrobes++;
                end
                if (fillStrobes == FILL_STROBES) begin
                    snapHist       = recentBits;
                    pendingCompute = 1'b1;
                end
            end
        end
    end

    // Output checks at the falling edge
    always @(negedge clk) begin
        sample_t expected;
        if (arstN) begin
            if (dueQ.size() > 0 && dueQ[0] == cycleCnt) begin
                assert (sampleValid) else reportMismatch("sampleValid", 1, 0);
                expected = expQ.pop_front();
                void'(dueQ.pop_front());
                assert (sampleOut == expected)
                else reportMismatch("sampleOut", int'(expected), int'(sampleOut));
                samplesChecked++;
            end else begin
                assert (!sampleValid) else abortRun("sampleValid pulsed with no sample due");
            end
        end
    end

    initial begin
        clk            = 1'b0;
        arstN          = 1'b0;
        bitIn          = 1'b0;
        wbReq          = '0;
        bitMode        = MODE_RANDOM;
        cycleCnt       = 0;
        samplesChecked = 0;
        recentBits     = '0;
        snapHist       = '0;
        pendingCompute = 1'b0;
        for (int i = 0; i < TAPS; i++) begin
            modelCoeffs[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        arstN = 1'b1;
        checkFillDelay();

        // Readback of random coefficients
        for (int i = 0; i < TAPS; i++) begin
            writeCoeff(i, randomCoeff());
        end
        for (int i = 0; i < TAPS; i++) begin
            readCoeffCheck(i);
        end

        waitSamples(120);

        // Extreme sums and sign mapping
        writeAllCoeffs(511);
        bitMode = MODE_ONES;
        waitSamples(8);
        checkHeldSample(4092);
        bitMode = MODE_ZEROS;
        waitSamples(8);
        checkHeldSample(4);
        bitMode = MODE_ONES;
        writeAllCoeffs(-512);
        waitSamples(8);
        checkHeldSample(0);

        // Update one coefficient while the stream runs
        for (int i = 0; i < TAPS; i++) begin
            writeCoeff(i, randomCoeff());
        end
        bitMode = MODE_RANDOM;
        waitSamples(10);
        writeCoeff(3, randomCoeff());
        waitSamples(10);

        // Reset in the middle of the stream
        arstN = 1'b0;
        for (int i = 0; i < TAPS; i++) begin
            modelCoeffs[i] = 0;
        end
        #1;
        assert (!sampleValid) else reportMismatch("sampleValid", 0, 1);
        assert (sampleOut == '0) else reportMismatch("sampleOut", 0, int'(sampleOut));
        repeat (RESET_CYCLES) nextCycle();
        arstN = 1'b1;
        checkFillDelay();
        for (int i = 0; i < TAPS; i++) begin
            writeCoeff(i, randomCoeff());
        end
        waitSamples(10);

        if (samplesChecked >= MIN_SAMPLES) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abortRun("Too few output samples were compared");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
firPkg.sv
coeffRegs.sv
tapHistory.sv
tapGroupSum.sv
outputScaler.sv
firDecimator.sv
firDecimator_props.sv
firDecimatorTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module firDecimatorTb -f flist.f -o simv \
    && ./obj_dir/simv \
    || { echo "Simulation failed"; exit 1; }
